/* source/isaPkg.sv */
// instruction set definitions for the reduced RV32I core
// data width, register index width and first fetch address
// major opcode and ALU operation enums
// instruction field positions and funct3 codes
package isaPkg;

	// datapath and address width
	localparam int xlen = 32;
	localparam int regAddrWidth = 5;
	localparam logic [xlen-1:0] resetPc = 32'h0000_0000;

	// field positions inside a 32-bit word
	localparam int opcodeLsb = 0;
	localparam int opcodeWidth = 7;
	localparam int rdLsb = 7;
	localparam int funct3Lsb = 12;
	localparam int funct3Width = 3;
	localparam int rs1Lsb = 15;
	localparam int rs2Lsb = 20;
	// funct7 bit 5 selects SUB over ADD
	localparam int subBit = 30;

	// funct3 values that change the ALU op
	localparam logic [funct3Width-1:0] funct3Or = 3'b110;
	localparam logic [funct3Width-1:0] funct3And = 3'b111;

	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OPIMM  = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111
	} opcode_t;

	typedef enum logic [2:0] {ADD, SUB, AND, OR, PASSB} aluOp_t;

endpackage

/* source/pipePkg.sv */
// pipeline control definitions shared by the stages and the hazard unit
// hazard class of the instruction held in a stage
// source select for an execute operand
package pipePkg;

	// hazard class, same encoding as the older core
	// lw and st occupy the data port, jmp covers branches and JAL
	typedef enum logic [1:0] {
		OTHER = 2'b00,
		JMP   = 2'b01,
		ST    = 2'b10,
		LW    = 2'b11
	} cmd_t;

	// where an execute operand comes from
	// REG  value read in decode
	// MEM  alu result sitting in the memory stage
	// WB   value leaving the writeback register
	typedef enum logic [1:0] {
		REG = 2'b00,
		MEM = 2'b01,
		WB  = 2'b10
	} fwdSel_t;

endpackage

/* source/fetchStage.sv */
// fetch stage
// program counter with redirect and hold
// fetch-to-decode register
`timescale 1ns/1ns

module fetchStage (
	input  logic clk,
	input  logic reset,
	input  logic stall,
	input  logic freeze,
	input  logic redirect,
	input  logic [isaPkg::xlen-1:0] redirectPc,
	input  logic [isaPkg::xlen-1:0] imemData,
	output logic [isaPkg::xlen-1:0] imemAddr,
	output logic [isaPkg::xlen-1:0] instrD,
	output logic [isaPkg::xlen-1:0] pcD,
	output logic validD
);

	logic [isaPkg::xlen-1:0] pc;

	// instruction memory answers in the same cycle
	assign imemAddr = pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= isaPkg::resetPc;
			validD <= 1'b0;
		end else if (!freeze) begin
			// redirect wins over a load-use hold
			if (redirect) begin
				pc <= redirectPc;
				// word fetched this cycle is on the wrong path
				validD <= 1'b0;
			end else if (!stall) begin
				pc <= pc + 'd4;
				validD <= 1'b1;
			end
		end
	end

	// fetched word and its pc
	always_ff @(posedge clk) begin
		if (!freeze && !stall) begin
			instrD <= imemData;
			pcD <= pc;
		end
	end

endmodule

/* source/decodeStage.sv */
// decode stage
// field split, immediate build and control decode
// register file, 31 entries, write-through from writeback
// decode-to-execute register with bubble insertion
`timescale 1ns/1ns

module decodeStage (
	input  logic clk,
	input  logic reset,
	input  logic [isaPkg::xlen-1:0] instr,
	input  logic [isaPkg::xlen-1:0] pc,
	input  logic valid,
	input  logic stall,
	input  logic flush,
	input  logic freeze,
	input  logic wbWrite,
	input  logic [isaPkg::regAddrWidth-1:0] wbRd,
	input  logic [isaPkg::xlen-1:0] wbData,
	output logic [isaPkg::regAddrWidth-1:0] rs1D,
	output logic [isaPkg::regAddrWidth-1:0] rs2D,
	output pipePkg::cmd_t cmdD,
	output logic [isaPkg::regAddrWidth-1:0] rs1E,
	output logic [isaPkg::regAddrWidth-1:0] rs2E,
	output logic [isaPkg::regAddrWidth-1:0] rdE,
	output logic [isaPkg::xlen-1:0] opAE,
	output logic [isaPkg::xlen-1:0] opBE,
	output logic [isaPkg::xlen-1:0] immE,
	output logic [isaPkg::xlen-1:0] pcE,
	output isaPkg::aluOp_t aluOpE,
	output pipePkg::cmd_t cmdE,
	output logic regWriteE,
	output logic branchE,
	output logic jumpE,
	output logic branchNeE,
	output logic validE
);

	isaPkg::opcode_t opcode;
	isaPkg::aluOp_t aluOp;
	logic [isaPkg::funct3Width-1:0] funct3;
	logic [isaPkg::regAddrWidth-1:0] rd;
	logic known;
	logic usesRs1;
	logic usesRs2;
	logic writesRd;
	logic immAsB;
	logic bubble;
	logic [isaPkg::xlen-1:0] imm;
	logic [isaPkg::xlen-1:0] rs1Val;
	logic [isaPkg::xlen-1:0] rs2Val;
	// x0 has no storage
	logic [isaPkg::xlen-1:0] regs [1:31];

	function automatic isaPkg::aluOp_t aluFromFunct3(input logic [2:0] f3, input logic sub);
		case (f3)
			isaPkg::funct3And: return isaPkg::AND;
			isaPkg::funct3Or: return isaPkg::OR;
			default: return sub ? isaPkg::SUB : isaPkg::ADD;
		endcase
	endfunction

	assign opcode = isaPkg::opcode_t'(instr[isaPkg::opcodeLsb +: isaPkg::opcodeWidth]);
	assign funct3 = instr[isaPkg::funct3Lsb +: isaPkg::funct3Width];
	assign rd = instr[isaPkg::rdLsb +: isaPkg::regAddrWidth];

	always_comb begin
		known = 1'b1;
		usesRs1 = 1'b0;
		usesRs2 = 1'b0;
		writesRd = 1'b0;
		immAsB = 1'b0;
		imm = '0;
		aluOp = isaPkg::ADD;
		cmdD = pipePkg::OTHER;
		case (opcode)
			isaPkg::OP: begin
				usesRs1 = 1'b1;
				usesRs2 = 1'b1;
				writesRd = 1'b1;
				aluOp = aluFromFunct3(funct3, instr[isaPkg::subBit]);
			end
			isaPkg::OPIMM: begin
				usesRs1 = 1'b1;
				writesRd = 1'b1;
				immAsB = 1'b1;
				imm = {{20{instr[31]}}, instr[31:20]};
				aluOp = aluFromFunct3(funct3, 1'b0);
			end
			isaPkg::LOAD: begin
				usesRs1 = 1'b1;
				writesRd = 1'b1;
				imm = {{20{instr[31]}}, instr[31:20]};
				cmdD = pipePkg::LW;
			end
			isaPkg::STORE: begin
				usesRs1 = 1'b1;
				usesRs2 = 1'b1;
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
				cmdD = pipePkg::ST;
			end
			isaPkg::BRANCH: begin
				usesRs1 = 1'b1;
				usesRs2 = 1'b1;
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
				aluOp = isaPkg::SUB;
				cmdD = pipePkg::JMP;
			end
			isaPkg::JAL: begin
				writesRd = 1'b1;
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
				aluOp = isaPkg::PASSB;
				cmdD = pipePkg::JMP;
			end
			default: known = 1'b0;
		endcase
	end

	// unused source fields read as x0 so there are no false hazards
	assign rs1D = usesRs1 ? instr[isaPkg::rs1Lsb +: isaPkg::regAddrWidth] : '0;
	assign rs2D = usesRs2 ? instr[isaPkg::rs2Lsb +: isaPkg::regAddrWidth] : '0;

	// write-through when writeback targets the same register
	assign rs1Val = (rs1D == '0) ? '0 : (wbWrite && wbRd == rs1D) ? wbData : regs[rs1D];
	assign rs2Val = (rs2D == '0) ? '0 : (wbWrite && wbRd == rs2D) ? wbData : regs[rs2D];

	always_ff @(posedge clk) begin
		// x0 writes dropped here
		if (wbWrite && wbRd != '0) begin
			regs[wbRd] <= wbData;
		end
	end

	// held instruction must not also move on
	// unknown words become bubbles
	assign bubble = flush || stall || !valid || !known;

	always_ff @(posedge clk) begin
		if (reset) begin
			validE <= 1'b0;
			regWriteE <= 1'b0;
			cmdE <= pipePkg::OTHER;
			branchE <= 1'b0;
			jumpE <= 1'b0;
		end else if (!freeze) begin
			validE <= !bubble;
			regWriteE <= !bubble && writesRd && rd != '0;
			cmdE <= bubble ? pipePkg::OTHER : cmdD;
			branchE <= !bubble && opcode == isaPkg::BRANCH;
			jumpE <= !bubble && opcode == isaPkg::JAL;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			rs1E <= rs1D;
			// immediate rides as operand b for OPIMM
			// rs2 reads x0 there
			rs2E <= rs2D;
			rdE <= rd;
			opAE <= rs1Val;
			opBE <= immAsB ? imm : rs2Val;
			immE <= imm;
			pcE <= pc;
			aluOpE <= aluOp;
			// funct3 bit 0 splits BNE from BEQ
			branchNeE <= funct3[0];
		end
	end

endmodule

/* source/executeStage.sv */
// execute stage
// operand forwarding muxes and ALU
// BEQ/BNE compare, branch and JAL target, JAL link value
// execute-to-memory register
`timescale 1ns/1ns

module executeStage (
	input  logic clk,
	input  logic reset,
	input  logic [isaPkg::regAddrWidth-1:0] rdE,
	input  logic [isaPkg::xlen-1:0] opAE,
	input  logic [isaPkg::xlen-1:0] opBE,
	input  logic [isaPkg::xlen-1:0] immE,
	input  logic [isaPkg::xlen-1:0] pcE,
	input  isaPkg::aluOp_t aluOpE,
	input  pipePkg::cmd_t cmdE,
	input  logic regWriteE,
	input  logic branchE,
	input  logic jumpE,
	input  logic branchNeE,
	input  logic validE,
	input  pipePkg::fwdSel_t fwdA,
	input  pipePkg::fwdSel_t fwdB,
	input  logic [isaPkg::xlen-1:0] aluResultFwd,
	input  logic [isaPkg::xlen-1:0] wbData,
	input  logic freeze,
	output logic redirect,
	output logic [isaPkg::xlen-1:0] redirectPc,
	output logic [isaPkg::xlen-1:0] aluResultM,
	output logic [isaPkg::xlen-1:0] storeDataM,
	output logic [isaPkg::regAddrWidth-1:0] rdM,
	output pipePkg::cmd_t cmdM,
	output logic regWriteM
);

	logic [isaPkg::xlen-1:0] srcA;
	logic [isaPkg::xlen-1:0] srcB;
	logic [isaPkg::xlen-1:0] aluB;
	logic [isaPkg::xlen-1:0] aluOut;
	logic [isaPkg::xlen-1:0] result;
	logic sameOps;

	function automatic logic [isaPkg::xlen-1:0] pickOperand(input pipePkg::fwdSel_t sel,
		input logic [isaPkg::xlen-1:0] regVal);
		case (sel)
			pipePkg::MEM: return aluResultFwd;
			pipePkg::WB: return wbData;
			default: return regVal;
		endcase
	endfunction

	always_comb begin
		srcA = pickOperand(fwdA, opAE);
		srcB = pickOperand(fwdB, opBE);
	end

	// loads and stores add the offset, srcB stays the store data
	assign aluB = (cmdE == pipePkg::LW || cmdE == pipePkg::ST) ? immE : srcB;

	always_comb begin
		case (aluOpE)
			isaPkg::SUB: aluOut = srcA - aluB;
			isaPkg::AND: aluOut = srcA & aluB;
			isaPkg::OR: aluOut = srcA | aluB;
			isaPkg::PASSB: aluOut = aluB;
			default: aluOut = srcA + aluB;
		endcase
	end

	assign sameOps = srcA == srcB;
	// bubbles never redirect
	assign redirect = validE && (jumpE || (branchE && (sameOps != branchNeE)));
	assign redirectPc = pcE + immE;
	// JAL links pc+4
	assign result = jumpE ? pcE + 'd4 : aluOut;

	always_ff @(posedge clk) begin
		if (reset) begin
			cmdM <= pipePkg::OTHER;
			regWriteM <= 1'b0;
		end else if (!freeze) begin
			cmdM <= cmdE;
			regWriteM <= regWriteE;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			aluResultM <= result;
			storeDataM <= srcB;
			rdM <= rdE;
		end
	end

endmodule

/* source/memoryStage.sv */
// memory stage
// data port strobe for LW and ST, freeze while the access waits
// load data or alu result into the writeback register
`timescale 1ns/1ns

module memoryStage (
	input  logic clk,
	input  logic reset,
	input  logic [isaPkg::xlen-1:0] aluResult,
	input  logic [isaPkg::xlen-1:0] storeData,
	input  logic [isaPkg::regAddrWidth-1:0] rd,
	input  pipePkg::cmd_t cmd,
	input  logic regWrite,
	input  logic dataStall,
	input  logic [isaPkg::xlen-1:0] dataRdata,
	output logic dataStb,
	output logic dataWe,
	output logic [isaPkg::xlen-1:0] dataAddr,
	output logic [isaPkg::xlen-1:0] dataWdata,
	output logic freeze,
	output logic wbWrite,
	output logic [isaPkg::regAddrWidth-1:0] wbRd,
	output logic [isaPkg::xlen-1:0] wbData
);

	logic wbWriteReg;

	assign dataStb = cmd == pipePkg::LW || cmd == pipePkg::ST;
	assign dataWe = cmd == pipePkg::ST;
	assign dataAddr = aluResult;
	assign dataWdata = storeData;
	// whole pipe waits on the data memory
	assign freeze = dataStb && dataStall;

	always_ff @(posedge clk) begin
		if (reset) begin
			wbWriteReg <= 1'b0;
		end else if (!freeze) begin
			wbWriteReg <= regWrite;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			wbRd <= rd;
			wbData <= (cmd == pipePkg::LW) ? dataRdata : aluResult;
		end
	end

	// held write lands once, in the cycle the wait ends
	assign wbWrite = wbWriteReg && !freeze;

	// word accesses only
	assert property (@(posedge clk) disable iff (reset)
		dataStb |-> dataAddr[1:0] == 2'b00);

endmodule

/* source/hazardUnit.sv */
// hazard unit
// MEM and WB forwarding selects for the execute operands
// load-use stall, redirect flush
`timescale 1ns/1ns

module hazardUnit (
	input  logic clk,
	input  logic reset,
	input  logic [isaPkg::regAddrWidth-1:0] rs1D,
	input  logic [isaPkg::regAddrWidth-1:0] rs2D,
	input  logic [isaPkg::regAddrWidth-1:0] rs1E,
	input  logic [isaPkg::regAddrWidth-1:0] rs2E,
	input  logic [isaPkg::regAddrWidth-1:0] rdE,
	input  pipePkg::cmd_t cmdE,
	input  logic regWriteE,
	input  logic [isaPkg::regAddrWidth-1:0] rdM,
	input  logic regWriteM,
	input  logic [isaPkg::regAddrWidth-1:0] wbRd,
	input  logic wbWrite,
	input  logic redirect,
	input  logic freeze,
	output pipePkg::fwdSel_t fwdA,
	output pipePkg::fwdSel_t fwdB,
	output logic stallF,
	output logic stallD,
	output logic flushD,
	output logic flushE
);

	logic loadUse;

	// younger result in MEM beats the one in WB
	function automatic pipePkg::fwdSel_t pickSource(
		input logic [isaPkg::regAddrWidth-1:0] rs);
		if (rs == '0) begin
			return pipePkg::REG;
		end else if (regWriteM && rdM == rs) begin
			return pipePkg::MEM;
		end else if (wbWrite && wbRd == rs) begin
			return pipePkg::WB;
		end
		return pipePkg::REG;
	endfunction

	always_comb begin
		fwdA = pickSource(rs1E);
		fwdB = pickSource(rs2E);
	end

	// load data only exists after the memory stage
	assign loadUse = cmdE == pipePkg::LW && regWriteE && rdE != '0 &&
		(rdE == rs1D || rdE == rs2D);

	// wrong-path decode word is dropped, not held
	assign stallF = loadUse && !redirect;
	assign stallD = loadUse && !redirect;
	assign flushD = redirect;
	// bubble into execute for a stall or a redirect
	assign flushE = loadUse || redirect;

	// pending write in memory never names x0
	assert property (@(posedge clk) disable iff (reset)
		regWriteM |-> rdM != '0);

	// load in execute that can flush never names x0
	assert property (@(posedge clk) disable iff (reset)
		regWriteE |-> rdE != '0);

	// redirect leaves a bubble in execute so the dropped word is never held
	assert property (@(posedge clk) disable iff (reset)
		redirect && !freeze |=> !stallD);

	// bubble in execute clears the dependency after one cycle
	assert property (@(posedge clk) disable iff (reset)
		stallD && !freeze |=> !stallD);

endmodule

/* source/cpuCore.sv */
// five-stage core top level
// fetch, decode, execute and memory stages plus the hazard unit
`timescale 1ns/1ns

module cpuCore (
	input  logic clk,
	input  logic reset,
	input  logic [isaPkg::xlen-1:0] imemData,
	input  logic dataStall,
	input  logic [isaPkg::xlen-1:0] dataRdata,
	output logic [isaPkg::xlen-1:0] imemAddr,
	output logic dataStb,
	output logic dataWe,
	output logic [isaPkg::xlen-1:0] dataAddr,
	output logic [isaPkg::xlen-1:0] dataWdata,
	output logic wbWrite,
	output logic [isaPkg::regAddrWidth-1:0] wbRd,
	output logic [isaPkg::xlen-1:0] wbData
);

	logic [isaPkg::xlen-1:0] instrD;
	logic [isaPkg::xlen-1:0] pcD;
	logic validD;
	logic [isaPkg::regAddrWidth-1:0] rs1D;
	logic [isaPkg::regAddrWidth-1:0] rs2D;
	logic [isaPkg::regAddrWidth-1:0] rs1E;
	logic [isaPkg::regAddrWidth-1:0] rs2E;
	logic [isaPkg::regAddrWidth-1:0] rdE;
	logic [isaPkg::xlen-1:0] opAE;
	logic [isaPkg::xlen-1:0] opBE;
	logic [isaPkg::xlen-1:0] immE;
	logic [isaPkg::xlen-1:0] pcE;
	isaPkg::aluOp_t aluOpE;
	pipePkg::cmd_t cmdE;
	logic regWriteE;
	logic branchE;
	logic jumpE;
	logic branchNeE;
	logic validE;
	logic redirect;
	logic [isaPkg::xlen-1:0] redirectPc;
	logic [isaPkg::xlen-1:0] aluResultM;
	logic [isaPkg::xlen-1:0] storeDataM;
	logic [isaPkg::regAddrWidth-1:0] rdM;
	pipePkg::cmd_t cmdM;
	logic regWriteM;
	logic freeze;
	pipePkg::fwdSel_t fwdA;
	pipePkg::fwdSel_t fwdB;
	logic stallF;
	logic stallD;
	logic flushD;
	logic flushE;

	// flushD is the redirect as seen by fetch, pc reload and dropped word
	fetchStage fetchStage_i (
		.clk(clk),
		.reset(reset),
		.stall(stallF),
		.freeze(freeze),
		.redirect(flushD),
		.redirectPc(redirectPc),
		.imemData(imemData),
		.imemAddr(imemAddr),
		.instrD(instrD),
		.pcD(pcD),
		.validD(validD)
	);

	// decode-side hazard class stays internal to decode
	decodeStage decodeStage_i (
		.clk(clk),
		.reset(reset),
		.instr(instrD),
		.pc(pcD),
		.valid(validD),
		.stall(stallD),
		.flush(flushE),
		.freeze(freeze),
		.wbWrite(wbWrite),
		.wbRd(wbRd),
		.wbData(wbData),
		.rs1D(rs1D),
		.rs2D(rs2D),
		.cmdD(),
		.rs1E(rs1E),
		.rs2E(rs2E),
		.rdE(rdE),
		.opAE(opAE),
		.opBE(opBE),
		.immE(immE),
		.pcE(pcE),
		.aluOpE(aluOpE),
		.cmdE(cmdE),
		.regWriteE(regWriteE),
		.branchE(branchE),
		.jumpE(jumpE),
		.branchNeE(branchNeE),
		.validE(validE)
	);

	executeStage executeStage_i (
		.clk(clk),
		.reset(reset),
		.rdE(rdE),
		.opAE(opAE),
		.opBE(opBE),
		.immE(immE),
		.pcE(pcE),
		.aluOpE(aluOpE),
		.cmdE(cmdE),
		.regWriteE(regWriteE),
		.branchE(branchE),
		.jumpE(jumpE),
		.branchNeE(branchNeE),
		.validE(validE),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.aluResultFwd(aluResultM),
		.wbData(wbData),
		.freeze(freeze),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.aluResultM(aluResultM),
		.storeDataM(storeDataM),
		.rdM(rdM),
		.cmdM(cmdM),
		.regWriteM(regWriteM)
	);

	memoryStage memoryStage_i (
		.clk(clk),
		.reset(reset),
		.aluResult(aluResultM),
		.storeData(storeDataM),
		.rd(rdM),
		.cmd(cmdM),
		.regWrite(regWriteM),
		.dataStall(dataStall),
		.dataRdata(dataRdata),
		.dataStb(dataStb),
		.dataWe(dataWe),
		.dataAddr(dataAddr),
		.dataWdata(dataWdata),
		.freeze(freeze),
		.wbWrite(wbWrite),
		.wbRd(wbRd),
		.wbData(wbData)
	);

	hazardUnit hazardUnit_i (
		.clk(clk),
		.reset(reset),
		.rs1D(rs1D),
		.rs2D(rs2D),
		.rs1E(rs1E),
		.rs2E(rs2E),
		.rdE(rdE),
		.cmdE(cmdE),
		.regWriteE(regWriteE),
		.rdM(rdM),
		.regWriteM(regWriteM),
		.wbRd(wbRd),
		.wbWrite(wbWrite),
		.redirect(redirect),
		.freeze(freeze),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.stallF(stallF),
		.stallD(stallD),
		.flushD(flushD),
		.flushE(flushE)
	);

endmodule

/* bench/testPrograms.svh */
// test programs for the core testbench
// per program: instruction words, expected writebacks in order, expected stores
// data memory words start as 0xD0000000 plus their byte address
`ifndef TEST_PROGRAMS_SVH
`define TEST_PROGRAMS_SVH

task automatic buildPrograms;
	// dependent alu chain, MEM and WB forwarding, x0 writes
	startProgram();
	addWord(encAddi(1, 0, 5));        expectWb(1, 32'h5);
	addWord(encAddi(2, 1, 7));        expectWb(2, 32'hc);
	addWord(encR(0, 0, 3, 1, 2));     expectWb(3, 32'h11);
	addWord(encR(32, 0, 4, 3, 1));    expectWb(4, 32'hc);
	addWord(encR(0, 7, 5, 4, 3));     expectWb(5, 32'h0);
	addWord(encR(0, 6, 6, 4, 3));     expectWb(6, 32'h1d);
	// x0 target gives no writeback
	addWord(encAddi(0, 1, 9));
	addWord(encR(0, 0, 7, 0, 2));     expectWb(7, 32'hc);
	addWord(encR(32, 0, 8, 0, 1));    expectWb(8, 32'hffff_fffb);

	// load-use on rs1 and rs2, store then load, store data forwarding
	startProgram();
	addWord(encAddi(1, 0, 64));       expectWb(1, 32'h40);
	addWord(encAddi(2, 0, 291));      expectWb(2, 32'h123);
	addWord(encSw(2, 1, 0));          expectStore(32'h40, 32'h123);
	addWord(encLw(3, 1, 0));          expectWb(3, 32'h123);
	addWord(encR(0, 0, 4, 3, 3));     expectWb(4, 32'h246);
	addWord(encLw(5, 1, 4));          expectWb(5, 32'hd000_0044);
	addWord(encR(32, 0, 6, 5, 2));    expectWb(6, 32'hcfff_ff21);
	addWord(encSw(6, 1, 8));          expectStore(32'h48, 32'hcfff_ff21);
	addWord(encLw(7, 1, 8));          expectWb(7, 32'hcfff_ff21);
	addWord(encR(0, 7, 8, 2, 7));     expectWb(8, 32'h121);

	// taken BEQ, not-taken BNE, JAL link, taken BNE on a forwarded value
	startProgram();
	addWord(encAddi(1, 0, 3));        expectWb(1, 32'h3);
	addWord(encAddi(2, 0, 3));        expectWb(2, 32'h3);
	addWord(encBranch(0, 1, 2, 12));
	addWord(encAddi(3, 0, 1));
	addWord(encAddi(4, 0, 2));
	addWord(encBranch(1, 1, 2, 8));
	addWord(encAddi(5, 0, 9));        expectWb(5, 32'h9);
	addWord(encJal(6, 12));           expectWb(6, 32'h20);
	addWord(encAddi(7, 0, 1));
	addWord(encAddi(8, 0, 2));
	addWord(encR(0, 0, 9, 6, 5));     expectWb(9, 32'h29);
	addWord(encBranch(1, 9, 0, 8));
	addWord(encAddi(10, 0, 7));
	addWord(encAddi(11, 9, 1));       expectWb(11, 32'h2a);
endtask

`endif

/* bench/cpuCoreTb.sv */
// testbench for the five-stage core
// clock, reset, instruction and data memory models with random data waits
// program table loop, writeback and store checks, pass/fail report
`timescale 1ns/1ns

module cpuCoreTb;

	localparam int maxProgs = 8;
	localparam int wbTimeout = 400;

	logic clk;
	logic reset;
	logic [31:0] imemData;
	logic dataStall;
	logic [31:0] dataRdata;
	logic [31:0] imemAddr;
	logic dataStb;
	logic dataWe;
	logic [31:0] dataAddr;
	logic [31:0] dataWdata;
	logic wbWrite;
	logic [4:0] wbRd;
	logic [31:0] wbData;

	// memories seen by the core
	logic [31:0] imem [256];
	logic [31:0] dmem [64];

	// program tables
	int progCount;
	int wordBase [maxProgs];
	int wordCount [maxProgs];
	int wbBase [maxProgs];
	int wbCount [maxProgs];
	int stBase [maxProgs];
	int stCount [maxProgs];
	logic [31:0] words [256];
	int expRd [256];
	logic [31:0] expVal [256];
	logic [31:0] expStAddr [64];
	logic [31:0] expStData [64];
	int totalWords;
	int totalWb;
	int totalSt;

	// run state
	int cur;
	int wbIdx;
	int stIdx;
	logic running;
	logic completing;
	int waitLeft;
	logic busy;

	cpuCore cpuCore_i (
		.clk(clk),
		.reset(reset),
		.imemData(imemData),
		.dataStall(dataStall),
		.dataRdata(dataRdata),
		.imemAddr(imemAddr),
		.dataStb(dataStb),
		.dataWe(dataWe),
		.dataAddr(dataAddr),
		.dataWdata(dataWdata),
		.wbWrite(wbWrite),
		.wbRd(wbRd),
		.wbData(wbData)
	);

	// instruction memory answers combinationally
	assign imemData = imem[imemAddr[9:2]];
	// read data only holds the word while an access completes
	assign dataRdata = (dataStb && !dataStall) ? dmem[dataAddr[7:2]] : ~dmem[dataAddr[7:2]];

	function automatic logic [31:0] encR(input int f7, input int f3, input int rd,
		input int rs1, input int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] encAddi(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
	endfunction

	function automatic logic [31:0] encLw(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
	endfunction

	function automatic logic [31:0] encSw(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	// f3 0 is BEQ, 1 is BNE
	function automatic logic [31:0] encBranch(input int f3, input int rs1, input int rs2,
		input int imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			7'b1100011};
	endfunction

	function automatic logic [31:0] encJal(input int rd, input int imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic startProgram;
		wordBase[progCount] = totalWords;
		wbBase[progCount] = totalWb;
		stBase[progCount] = totalSt;
		wordCount[progCount] = 0;
		wbCount[progCount] = 0;
		stCount[progCount] = 0;
		progCount++;
	endtask

	task automatic addWord(input logic [31:0] w);
		words[totalWords] = w;
		totalWords++;
		wordCount[progCount-1]++;
	endtask

	task automatic expectWb(input int rd, input logic [31:0] val);
		expRd[totalWb] = rd;
		expVal[totalWb] = val;
		totalWb++;
		wbCount[progCount-1]++;
	endtask

	task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
		expStAddr[totalSt] = addr;
		expStData[totalSt] = data;
		totalSt++;
		stCount[progCount-1]++;
	endtask

	`include "testPrograms.svh"

	task automatic failRun(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			failRun($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic loadProgram(input int p);
		// unused words are ADDI x0,x0,0
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'h0000_0013;
		end
		for (int i = 0; i < wordCount[p]; i++) begin
			imem[i] = words[wordBase[p] + i];
		end
		for (int i = 0; i < 64; i++) begin
			dmem[i] = 32'hd000_0000 | 32'(i * 4);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// writeback monitor sampled mid-cycle
	always @(negedge clk) begin
		if (running && wbWrite) begin
			if (wbIdx >= wbCount[cur]) begin
				failRun($sformatf("program %0d wrote back more results than expected", cur));
			end else begin
				checkValue("wbRd", 32'(wbRd), 32'(expRd[wbBase[cur] + wbIdx]));
				checkValue("wbData", wbData, expVal[wbBase[cur] + wbIdx]);
				wbIdx++;
			end
		end
	end

	// store side of the data memory
	// access ends at the edge after dataStall goes low
	always @(negedge clk) begin
		completing = dataStb && !dataStall;
		if (running && completing && dataWe) begin
			if (stIdx >= stCount[cur]) begin
				failRun($sformatf("program %0d stored more words than expected", cur));
			end else begin
				checkValue("dataAddr", dataAddr, expStAddr[stBase[cur] + stIdx]);
				checkValue("dataWdata", dataWdata, expStData[stBase[cur] + stIdx]);
				dmem[dataAddr[7:2]] = dataWdata;
				stIdx++;
			end
		end
	end

	// random wait of 0 to 3 cycles per access
	always @(posedge clk) begin
		#5;
		if (reset || !dataStb) begin
			busy = 1'b0;
			waitLeft = 0;
		end else begin
			if (!busy || completing) begin
				waitLeft = int'($urandom % 4);
			end else if (waitLeft > 0) begin
				waitLeft--;
			end
			busy = 1'b1;
		end
		dataStall = (waitLeft != 0);
	end

	initial begin
		int cycles;
		reset = 1'b1;
		dataStall = 1'b0;
		running = 1'b0;
		completing = 1'b0;
		busy = 1'b0;
		waitLeft = 0;
		progCount = 0;
		totalWords = 0;
		totalWb = 0;
		totalSt = 0;
		cur = 0;
		wbIdx = 0;
		stIdx = 0;
		void'($urandom(32'h8d50fd5c));
		buildPrograms();
		for (int p = 0; p < progCount; p++) begin
			@(posedge clk);
			#5;
			running = 1'b0;
			reset = 1'b1;
			cur = p;
			wbIdx = 0;
			stIdx = 0;
			loadProgram(p);
			repeat (5) @(posedge clk);
			#5;
			reset = 1'b0;
			running = 1'b1;
			cycles = 0;
			while (wbIdx < wbCount[p]) begin
				@(posedge clk);
				cycles++;
				if (cycles > wbTimeout) begin
					failRun($sformatf("program %0d timed out after %0d of %0d writebacks",
						p, wbIdx, wbCount[p]));
				end
			end
			// let skipped or stray instructions drain out
			repeat (12) @(posedge clk);
			if (stIdx != stCount[p]) begin
				failRun($sformatf("program %0d made %0d stores, expected %0d",
					p, stIdx, stCount[p]));
			end
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+bench
source/isaPkg.sv
source/pipePkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/hazardUnit.sv
source/cpuCore.sv
bench/cpuCoreTb.sv

/* run.sh */
#!/bin/sh
# build the core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module cpuCoreTb -o simv
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed"
	exit $status
fi

./obj_dir/simv
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed"
	exit $status
fi

exit 0
